// ==== vlog.f ====
+incdir+tests
src/fsync_pkg.sv
src/fsync_fifo.sv
src/fsync_rr_arbiter.sv
src/fsync_barrier_fsm.sv
src/fsync_node.sv
tests/tb_fsync_node.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fsync_node testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_fsync_node -Mdir obj_dir -o sim_fsync_node
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_fsync_node 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'STATUS: PASS'; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== tests/tb_fsync_tasks.svh ====
`ifndef TB_FSYNC_TASKS_SVH
`define TB_FSYNC_TASKS_SVH

// ****************************************
// Checks, stimulus and waits
// ****************************************

task automatic check_eq(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
  if (actual !== expected) begin
    $display("[ERROR] t=%0d ns %s: expected 0x%0h, got 0x%0h",
             $time, name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "Value mismatch");
  end
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x ^ (x << 13);
  s = s ^ (s >> 17);
  return s ^ (s << 5);
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// Random aggregation field, bit 0 chosen by caller
function automatic logic [AGGR_W-1:0] rand_aggr(input logic last_level);
  logic [AGGR_W-1:0] a;
  a    = AGGR_W'(next_rand());
  a[0] = last_level;
  return a;
endfunction

function automatic void clear_inputs();
  req_valid_i    = '0;
  req_aggr_i     = '{default: '0};
  req_id_i       = '{default: '0};
  rsp_in_valid_i = 1'b0;
  rsp_in_id_i    = '0;
endfunction

task automatic apply_reset();
  @(negedge clk_i);
  rst_ni = 1'b0;
  clear_inputs();
  repeat (3) @(negedge clk_i);
  rst_ni = 1'b1;
endtask

task automatic send_req(input int child, input fsync_id_t id, input logic [AGGR_W-1:0] aggr);
  @(negedge clk_i);
  req_valid_i[child] = 1'b1;
  req_id_i[child]    = id;
  req_aggr_i[child]  = aggr;
  @(negedge clk_i);
  req_valid_i = '0;
endtask

// East and west strobe in the same cycle
task automatic send_pair(input fsync_id_t id, input logic [AGGR_W-1:0] aggr_e,
                         input logic [AGGR_W-1:0] aggr_w);
  @(negedge clk_i);
  req_valid_i   = '1;
  req_id_i[0]   = id;
  req_id_i[1]   = id;
  req_aggr_i[0] = aggr_e;
  req_aggr_i[1] = aggr_w;
  @(negedge clk_i);
  req_valid_i = '0;
endtask

task automatic send_parent_rsp(input fsync_id_t id);
  @(negedge clk_i);
  rsp_in_valid_i = 1'b1;
  rsp_in_id_i    = id;
  @(negedge clk_i);
  rsp_in_valid_i = 1'b0;
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(posedge clk_i);
endtask

task automatic wait_pulses(input string what, input logic forward, input int target);
  int cycles;
  int seen;
  cycles = 0;
  do begin
    @(posedge clk_i);
    cycles++;
    seen = forward ? fwd_count : rsp_count;
  end while (seen < target && cycles < PULSE_WAIT);
  if (seen < target) begin
    $display("%s number %0d never came within %0d cycles", what, target, PULSE_WAIT);
    $display("STATUS: FAIL");
    $fatal(1, "Missing output pulse");
  end
endtask

task automatic check_one_rsp(input fsync_id_t k);
  check_eq("rsp_valid_o pulse count", 1, rsp_count);
  check_eq("rsp_valid_o", 32'({N_CHILD{1'b1}}), 32'(rsp_bits[0]));  // Both children
  check_eq("rsp_id_o", 32'(k), 32'(rsp_ids[0]));
  check_eq("req_out_valid_o pulse count", 0, fwd_count);
endtask

// ****************************************
// Directed tests
// ****************************************

task automatic test_local_barrier();
  fsync_id_t k;
  $display("Test: local barrier");
  apply_reset();
  check_eq("overflow_o", 0, 32'(overflow_o));
  k = fsync_id_t'(next_rand());
  send_pair(k, rand_aggr(1'b1), rand_aggr(1'b1));
  wait_pulses("Child response", 1'b0, 1);
  idle_cycles(QUIET);
  check_one_rsp(k);
endtask

task automatic test_forward_up();
  fsync_id_t         k;
  logic [AGGR_W-1:0] aggr;
  $display("Test: forwarding to parent");
  apply_reset();
  k    = fsync_id_t'(next_rand());
  aggr = rand_aggr(1'b0);
  send_pair(k, aggr, aggr);
  wait_pulses("Parent request", 1'b1, 1);
  idle_cycles(QUIET);
  check_eq("req_out_valid_o pulse count", 1, fwd_count);
  check_eq("req_out_id_o", 32'(k), 32'(fwd_ids[0]));
  check_eq("req_out_aggr_o", 32'(aggr >> 1), 32'(fwd_aggrs[0]));  // One level climbed
  check_eq("rsp_valid_o pulse count", 0, rsp_count);
endtask

task automatic test_parent_broadcast();
  fsync_id_t k;
  $display("Test: parent response broadcast");
  apply_reset();
  k = fsync_id_t'(next_rand());
  send_parent_rsp(k);
  wait_pulses("Child response", 1'b0, 1);
  idle_cycles(QUIET);
  check_one_rsp(k);
endtask

task automatic test_partial_interleaved();
  fsync_id_t order [N_IDS];
  int        seen [N_IDS];
  fsync_id_t tmp;
  int        j;
  $display("Test: partial and interleaved barriers");
  apply_reset();
  for (int i = 0; i < N_IDS; i++) begin
    order[i] = fsync_id_t'(i);
    seen[i]  = 0;
    send_req(0, fsync_id_t'(i), rand_aggr(1'b1));
  end
  idle_cycles(PULSE_WAIT);
  check_eq("rsp_valid_o pulses, east only", 0, rsp_count);
  check_eq("req_out_valid_o pulses, east only", 0, fwd_count);
  for (int i = N_IDS - 1; i > 0; i--) begin  // Fisher-Yates
    j        = int'(next_rand() % 32'(i + 1));
    tmp      = order[i];
    order[i] = order[j];
    order[j] = tmp;
  end
  for (int i = 0; i < N_IDS; i++) begin
    send_req(1, order[i], rand_aggr(1'b1));
  end
  for (int n = 1; n <= N_IDS; n++) begin
    wait_pulses("Child response", 1'b0, n);
  end
  idle_cycles(QUIET);
  check_eq("rsp_valid_o pulse count", N_IDS, rsp_count);
  check_eq("req_out_valid_o pulse count", 0, fwd_count);
  for (int i = 0; i < N_IDS; i++) begin
    check_eq("rsp_valid_o", 32'({N_CHILD{1'b1}}), 32'(rsp_bits[i]));
    seen[rsp_ids[i]]++;
  end
  for (int i = 0; i < N_IDS; i++) begin
    check_eq($sformatf("responses with id %0d", i), 1, seen[i]);
  end
endtask

task automatic test_overflow();
  int burst;
  $display("Test: overflow");
  burst = 2 * FIFO_DEPTH + 2;
  apply_reset();
  check_eq("overflow_o", 0, 32'(overflow_o));
  @(negedge clk_i);
  for (int n = 0; n < burst; n++) begin  // East strobes every cycle
    req_valid_i[0] = 1'b1;
    req_id_i[0]    = fsync_id_t'(next_rand());
    req_aggr_i[0]  = rand_aggr(1'b1);
    @(negedge clk_i);
  end
  req_valid_i = '0;
  check_eq("overflow_o", 1, 32'(overflow_o));
  idle_cycles(QUIET);
  check_eq("overflow_o, sticky", 1, 32'(overflow_o));
  check_eq("rsp_valid_o pulses, east only", 0, rsp_count);
  apply_reset();
  check_eq("overflow_o after reset", 0, 32'(overflow_o));
endtask

`endif

// ==== tests/tb_fsync_node.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fsync_node;

  import fsync_pkg::*;

  localparam int          CLK_PERIOD  = 4;
  localparam int          N_TESTS     = 5;
  localparam int          WATCHDOG_NS = N_TESTS * 400 * CLK_PERIOD;
  localparam int          PULSE_WAIT  = 50;  // Cycles allowed per expected pulse
  localparam int          QUIET       = 20;  // Settle time before counting pulses
  localparam logic [31:0] SEED        = 32'h5d9d_05b2;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic [N_CHILD-1:0]  req_valid_i;
  logic [AGGR_W-1:0]   req_aggr_i [N_CHILD];
  fsync_id_t           req_id_i [N_CHILD];
  logic [N_CHILD-1:0]  rsp_valid_o;
  fsync_id_t           rsp_id_o;
  logic                req_out_valid_o;
  logic [AGGR_W-1:0]   req_out_aggr_o;
  fsync_id_t           req_out_id_o;
  logic                rsp_in_valid_i;
  fsync_id_t           rsp_in_id_i;
  logic                overflow_o;

  logic [31:0]         rng_state;

  // Observed output pulses, cleared while in reset
  int                  rsp_count;
  int                  fwd_count;
  fsync_id_t           rsp_ids [$];
  logic [N_CHILD-1:0]  rsp_bits [$];
  fsync_id_t           fwd_ids [$];
  logic [AGGR_W-1:0]   fwd_aggrs [$];

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  fsync_node u_fsync_node (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .req_valid_i     ( req_valid_i     ),
    .req_aggr_i      ( req_aggr_i      ),
    .req_id_i        ( req_id_i        ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_id_o        ( rsp_id_o        ),
    .req_out_valid_o ( req_out_valid_o ),
    .req_out_aggr_o  ( req_out_aggr_o  ),
    .req_out_id_o    ( req_out_id_o    ),
    .rsp_in_valid_i  ( rsp_in_valid_i  ),
    .rsp_in_id_i     ( rsp_in_id_i     ),
    .overflow_o      ( overflow_o      )
  );

  // ****************************************
  // Output monitor
  // ****************************************

  // Outputs are registered, so mid-cycle sampling sees settled values
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      rsp_count = 0;
      fwd_count = 0;
      rsp_ids.delete();
      rsp_bits.delete();
      fwd_ids.delete();
      fwd_aggrs.delete();
    end else begin
      if (rsp_valid_o != '0) begin
        rsp_count++;
        rsp_ids.push_back(rsp_id_o);
        rsp_bits.push_back(rsp_valid_o);
      end
      if (req_out_valid_o) begin  // Request to parent
        fwd_count++;
        fwd_ids.push_back(req_out_id_o);
        fwd_aggrs.push_back(req_out_aggr_o);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clear_inputs();
    rst_ni    = 1'b0;
    rng_state = SEED;
    test_local_barrier();
    test_forward_up();
    test_parent_broadcast();
    test_partial_interleaved();
    test_overflow();
    $display("STATUS: PASS");
    $finish;
  end

  `include "tb_fsync_tasks.svh"

endmodule

`default_nettype wire

// ==== src/fsync_node.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsync_node (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  // Children
  input  wire logic [fsync_pkg::N_CHILD-1:0] req_valid_i,
  input  wire logic [fsync_pkg::AGGR_W-1:0]  req_aggr_i [fsync_pkg::N_CHILD],
  input  wire fsync_pkg::fsync_id_t          req_id_i [fsync_pkg::N_CHILD],
  output logic [fsync_pkg::N_CHILD-1:0]      rsp_valid_o,
  output fsync_pkg::fsync_id_t               rsp_id_o,
  // Parent
  output logic                               req_out_valid_o,
  output logic [fsync_pkg::AGGR_W-1:0]       req_out_aggr_o,
  output fsync_pkg::fsync_id_t               req_out_id_o,
  input  wire logic                          rsp_in_valid_i,
  input  wire fsync_pkg::fsync_id_t          rsp_in_id_i,
  output logic                               overflow_o
);

  import fsync_pkg::*;

  fsync_req_t          child_req [N_CHILD];
  fsync_req_t          rx_head [N_CHILD];
  logic [N_CHILD-1:0]  rx_empty;
  logic [N_CHILD-1:0]  rx_pop;
  logic [N_CHILD-1:0]  rx_ovf;

  fsync_req_t          arb_req;
  logic                arb_src;
  logic                arb_empty;
  logic                arb_take;

  fsync_id_t           prsp_id;
  logic                prsp_empty;
  logic                prsp_pop;
  logic                prsp_ovf;

  // ****************************************
  // Child RX FIFOs
  // ****************************************

  for (genvar i = 0; i < N_CHILD; i++) begin : gen_rx
    assign child_req[i] = '{aggr: req_aggr_i[i], id: req_id_i[i]};

    fsync_fifo #(
      .payload_t ( fsync_req_t ),
      .DEPTH     ( FIFO_DEPTH  )
    ) u_rx_fifo (
      .clk_i      ( clk_i          ),
      .rst_ni     ( rst_ni         ),
      .push_i     ( req_valid_i[i] ),
      .data_i     ( child_req[i]   ),
      .pop_i      ( rx_pop[i]      ),
      .data_o     ( rx_head[i]     ),
      .empty_o    ( rx_empty[i]    ),
      .overflow_o ( rx_ovf[i]      )
    );
  end

  fsync_rr_arbiter u_rr_arbiter (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .empty_i     ( rx_empty  ),
    .req_i       ( rx_head   ),
    .take_i      ( arb_take  ),
    .pop_o       ( rx_pop    ),
    .req_o       ( arb_req   ),
    .src_o       ( arb_src   ),
    .req_empty_o ( arb_empty )
  );

  // Parent responses keep only the id
  fsync_fifo #(
    .payload_t ( fsync_id_t ),
    .DEPTH     ( FIFO_DEPTH )
  ) u_prsp_fifo (
    .clk_i      ( clk_i          ),
    .rst_ni     ( rst_ni         ),
    .push_i     ( rsp_in_valid_i ),
    .data_i     ( rsp_in_id_i    ),
    .pop_i      ( prsp_pop       ),
    .data_o     ( prsp_id        ),
    .empty_o    ( prsp_empty     ),
    .overflow_o ( prsp_ovf       )
  );

  fsync_barrier_fsm u_barrier_fsm (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .req_empty_i     ( arb_empty       ),
    .req_i           ( arb_req         ),
    .src_i           ( arb_src         ),
    .take_o          ( arb_take        ),
    .prsp_empty_i    ( prsp_empty      ),
    .prsp_id_i       ( prsp_id         ),
    .prsp_pop_o      ( prsp_pop        ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_id_o        ( rsp_id_o        ),
    .req_out_valid_o ( req_out_valid_o ),
    .req_out_aggr_o  ( req_out_aggr_o  ),
    .req_out_id_o    ( req_out_id_o    )
  );

  assign overflow_o = (|rx_ovf) | prsp_ovf;

endmodule

`default_nettype wire

// ==== src/fsync_barrier_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsync_barrier_fsm (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  // Merged child requests
  input  wire logic                         req_empty_i,
  input  wire fsync_pkg::fsync_req_t        req_i,
  input  wire logic                         src_i,
  output logic                              take_o,
  // Parent response FIFO
  input  wire logic                         prsp_empty_i,
  input  wire fsync_pkg::fsync_id_t         prsp_id_i,
  output logic                              prsp_pop_o,
  // Responses to both children
  output logic [fsync_pkg::N_CHILD-1:0]     rsp_valid_o,
  output fsync_pkg::fsync_id_t              rsp_id_o,
  // Request to parent
  output logic                              req_out_valid_o,
  output logic [fsync_pkg::AGGR_W-1:0]      req_out_aggr_o,
  output fsync_pkg::fsync_id_t              req_out_id_o
);

  import fsync_pkg::*;

  fsm_state_e          state_q;
  fsm_state_e          state_d;

  // Latched event
  logic                evt_parent_q;
  fsync_id_t           evt_id_q;
  logic [AGGR_W-1:0]   evt_aggr_q;
  logic                evt_src_q;

  logic [N_CHILD-1:0]  arrived_q [N_IDS];  // One bit per child and id
  logic [N_CHILD-1:0]  entry_next;
  logic                all_arrived;

  // Arrival vector including the current child
  assign entry_next  = arrived_q[evt_id_q] | (N_CHILD'(1) << evt_src_q);
  assign all_arrived = &entry_next;

  // ****************************************
  // Next state and FIFO pops
  // ****************************************

  always_comb begin
    state_d    = state_q;
    take_o     = 1'b0;
    prsp_pop_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (!prsp_empty_i) begin  // Parent responses first
          prsp_pop_o = 1'b1;
          state_d    = LOOKUP;
        end else if (!req_empty_i) begin
          take_o  = 1'b1;
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (evt_parent_q) begin
          state_d = RESPOND;
        end else if (all_arrived) begin
          // Barrier ends here or climbs one level
          state_d = evt_aggr_q[0] ? RESPOND : FORWARD;
        end else begin
          state_d = IDLE;
        end
      end
      RESPOND: state_d = IDLE;
      FORWARD: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Event payload, held stable until the next pop
  always_ff @(posedge clk_i) begin
    if (prsp_pop_o) begin
      evt_parent_q <= 1'b1;
      evt_id_q     <= prsp_id_i;
    end else if (take_o) begin
      evt_parent_q <= 1'b0;
      evt_id_q     <= req_i.id;
      evt_aggr_q   <= req_i.aggr;
      evt_src_q    <= src_i;
    end
  end

  // ****************************************
  // Arrival table
  // ****************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_IDS; i++) begin
        arrived_q[i] <= '0;
      end
    end else if (state_q == LOOKUP && !evt_parent_q) begin
      if (all_arrived) begin
        arrived_q[evt_id_q] <= '0;  // Barrier complete, free the entry
      end else begin
        arrived_q[evt_id_q] <= entry_next;  // Duplicates leave it unchanged
      end
    end
  end

  // ****************************************
  // Output strobes
  // ****************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o     <= '0;
      req_out_valid_o <= 1'b0;
    end else begin
      rsp_valid_o     <= {N_CHILD{state_d == RESPOND}};
      req_out_valid_o <= (state_d == FORWARD);
    end
  end

  assign rsp_id_o       = evt_id_q;
  assign req_out_id_o   = evt_id_q;
  assign req_out_aggr_o = evt_aggr_q >> 1;  // One level consumed

  // A completed barrier never stays in the table
  a_entry_freed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == LOOKUP && !evt_parent_q) |-> !(&arrived_q[evt_id_q]))
    else $error("fsync_barrier_fsm: completed barrier left in arrival table");

endmodule

`default_nettype wire

// ==== src/fsync_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsync_rr_arbiter (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic [fsync_pkg::N_CHILD-1:0] empty_i,
  input  wire fsync_pkg::fsync_req_t         req_i [fsync_pkg::N_CHILD],
  input  wire logic                          take_i,
  output logic [fsync_pkg::N_CHILD-1:0]      pop_o,
  output fsync_pkg::fsync_req_t              req_o,
  output logic                               src_o,
  output logic                               req_empty_o
);

  import fsync_pkg::*;

  logic ptr_q;      // Highest priority port, starts on east
  logic grant_idx;
  logic cand;
  logic found;

  // First non-empty port at or after the pointer
  always_comb begin
    grant_idx = ptr_q;
    found     = 1'b0;
    for (int off = 0; off < N_CHILD; off++) begin
      cand = 1'((int'(ptr_q) + off) % N_CHILD);
      if (!found && !empty_i[cand]) begin
        grant_idx = cand;
        found     = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_CHILD; i++) begin
      pop_o[i] = take_i && found && (int'(grant_idx) == i);
    end
  end

  assign req_o       = req_i[grant_idx];
  assign src_o       = grant_idx;
  assign req_empty_o = &empty_i;

  // Move past the granted port on every take
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= 1'b0;
    end else if (take_i && found) begin
      ptr_q <= 1'((int'(grant_idx) + 1) % N_CHILD);
    end
  end

  // Consumer takes only when a request is pending
  a_take_when_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    take_i |-> !req_empty_o)
    else $error("fsync_rr_arbiter: take with no pending request");

endmodule

`default_nettype wire

// ==== src/fsync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsync_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          empty_o,
  output logic          overflow_o
);

  payload_t                     mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         full;
  logic                         do_push;
  logic                         do_pop;

  assign full    = (count_q == $bits(count_q)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full;   // No back-pressure, drop when full
  assign do_pop  = pop_i && !empty_o;

  assign data_o = mem_q[rd_ptr_q];  // Head is visible without a pop

  // ****************************************
  // Pointers and fill count
  // ****************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == $bits(wr_ptr_q)'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == $bits(rd_ptr_q)'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      overflow_o <= 1'b0;
    end else if (push_i && full) begin
      overflow_o <= 1'b1;
    end
  end

  // Consumer must only pop a non-empty FIFO
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_i && empty_o))
    else $error("fsync_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== src/fsync_pkg.sv ====
`default_nettype none

package fsync_pkg;

  // ****************************************
  // Sizes
  // ****************************************

  localparam int unsigned N_CHILD    = 2;  // 0 is east, 1 is west
  localparam int unsigned AGGR_W     = 4;
  localparam int unsigned ID_W       = 2;
  localparam int unsigned N_IDS      = 4;  // Arrival table depth
  localparam int unsigned FIFO_DEPTH = 4;

  // ****************************************
  // Types
  // ****************************************

  // Barrier id, also the parent response payload
  typedef logic [ID_W-1:0] fsync_id_t;

  // Child request as stored in the RX FIFOs
  // aggr bit 0 set means the barrier ends at this level
  typedef struct packed {
    logic [AGGR_W-1:0] aggr;
    fsync_id_t         id;
  } fsync_req_t;

  // Control FSM states
  typedef enum logic [1:0] {
    IDLE,     // Pop one event
    LOOKUP,   // Update arrival table
    RESPOND,  // Pulse both child responses
    FORWARD   // Pulse request to parent
  } fsm_state_e;

endpackage

`default_nettype wire
